//--- list.f
common/trig_pkg.sv
common/daq_pkg.sv
rtl/trig_sync.sv
trigger/trigger_fsm.sv
trigger/trig_num_fifo.sv
rtl/daq_formatter.sv
rtl/led_flasher.sv
rtl/wfd_trig_top.sv
bench/tb_clk_gen.sv
bench/tb_wfd_trig.sv

//--- Bender.yml
package:
  name: wfd_trig

sources:
  - common/trig_pkg.sv
  - common/daq_pkg.sv
  - rtl/trig_sync.sv
  - trigger/trigger_fsm.sv
  - trigger/trig_num_fifo.sv
  - rtl/daq_formatter.sv
  - rtl/led_flasher.sv
  - rtl/wfd_trig_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_wfd_trig.sv

//--- bench/tb_wfd_trig.sv
// testbench for the trigger and readout top with channel models, reference events, comparator
module tb_wfd_trig;
    timeunit 1ns;
    timeprecision 100ps;
    import trig_pkg::*;
    import daq_pkg::*;

    localparam int N_TRIGS = 14;            // triggers sent over the whole run

    logic       clk125;
    logic       rst_n;
    logic       ext_trig;
    chan_mask_t chan_en;
    board_id_t  board_id;
    wire chan_mask_t acq_dones;             // one bit per channel model
    logic       daq_ready;
    chan_mask_t acq_trigs;
    chan_mask_t trig_arm;
    daq_word_t  daq_out;
    logic       led0;
    logic       led1;

    integer     seed = 32'h88d7;
    string      test_name = "reset";
    int         go_count = 0;               // go pulses seen
    int         events_seen = 0;            // complete events accepted
    trig_num_t  exp_num = '0;               // next fill number expected
    int         word_idx = 0;
    logic       held = 1'b0;                // last word stalled by the link
    daq_word_t  held_word;

    tb_clk_gen u_clk_gen (.clk(clk125), .rst_n(rst_n));

    wfd_trig_top u_dut (
        .clk125    (clk125),
        .rst_n     (rst_n),
        .ext_trig  (ext_trig),
        .chan_en   (chan_en),
        .board_id  (board_id),
        .acq_dones (acq_dones),
        .daq_ready (daq_ready),
        .acq_trigs (acq_trigs),
        .trig_arm  (trig_arm),
        .daq_out   (daq_out),
        .led0      (led0),
        .led1      (led1)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input logic [66:0] exp, input logic [66:0] act);
        assert (act === exp) else begin
            $display("FAIL %s/%s expected %h actual %h", test_name, what, exp, act);
            fail_run("value mismatch");
        end
    endtask

    // header, body, trailer of fill n
    function automatic logic [2:0][DAQ_W-1:0] expected_event(
        input trig_num_t n,
        input board_id_t bid,
        input chan_mask_t en
    );
        logic [2:0][DAQ_W-1:0] w;
        w = '0;
        w[0][63:56] = 8'h5a;
        w[0][34:32] = bid;
        w[0][23:0]  = n;
        w[1][36:32] = en;                   // body carries the channel mask
        w[1][23:0]  = n;
        w[2][63:56] = 8'ha5;
        w[2][35:32] = 4'd3;                 // three words per event
        w[2][23:0]  = n;
        return w;
    endfunction

    task automatic step(input int n);       // leaves us 1 ns after an edge
        repeat (n) @(posedge clk125);
        #1;
    endtask

    task automatic pulse_trig(input int hi_cycles);
        ext_trig = 1'b1;
        step(hi_cycles);
        ext_trig = 1'b0;
        step(40);                           // spacing beyond the slowest channel
    endtask

    task automatic wait_events(input int n);
        while (events_seen < n) step(1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // channel models
    //////////////////////////////////////////////////////////////////////

    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
        logic done;
        assign acq_dones[c] = done;
        initial begin
            int unsigned dly;
            done = 1'b0;
            forever begin
                @(posedge clk125);
                if (acq_trigs[c] === 1'b1) begin
                    #1 done = 1'b0;                     // new fill clears done
                    dly = 1 + ({$random(seed)} % 20);
                    repeat (dly) @(posedge clk125);
                    #1 done = 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // comparator
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk125) begin : compare
        logic [2:0][DAQ_W-1:0] exp_evt;
        logic [66:0]           exp_word;
        if (rst_n) begin
            check_eq("led0", 67'(daq_ready), 67'(led0));
            if (|acq_trigs) begin
                check_eq("go", 67'(chan_en), 67'(acq_trigs));
                go_count++;
            end
            if (held) check_eq("hold", held_word, daq_out);    // stalled word must not move
            held      = daq_out.valid && !daq_ready;
            held_word = daq_out;
            if (daq_out.valid && daq_ready) begin
                exp_evt  = expected_event(exp_num, board_id, chan_en);
                exp_word = {1'b1, word_idx == 0, word_idx == 2, exp_evt[word_idx]};
                check_eq("event word", exp_word, daq_out);
                if (word_idx == 2) begin
                    word_idx = 0;
                    exp_num++;
                    events_seen++;
                end else begin
                    word_idx++;
                end
            end
        end
    end

    // watchdog
    initial begin
        repeat (200 * N_TRIGS + 2000) @(posedge clk125);
        fail_run("timeout: the tests did not finish in the expected time");
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int base_go;
        int cnt;
        logic prev;
        ext_trig  = 1'b0;
        chan_en   = 5'b11111;
        board_id  = 3'd5;
        daq_ready = 1'b1;
        wait (rst_n === 1'b1);
        step(1);
        check_eq("acq_trigs", '0, 67'(acq_trigs));
        check_eq("valid", '0, 67'(daq_out.valid));
        check_eq("led1", '0, 67'(led1));
        check_eq("trig_arm", 67'(chan_en), 67'(trig_arm));

        test_name = "numbering";
        for (int i = 0; i < 4; i++) begin
            pulse_trig(2);
            wait_events(i + 1);
            check_eq("go count", 67'(i + 1), 67'(go_count));
        end

        test_name = "long level";
        pulse_trig(60);
        wait_events(5);
        step(40);
        check_eq("go count", 67'd5, 67'(go_count));
        check_eq("events", 67'd5, 67'(events_seen));

        test_name = "chan_en";
        chan_en = 5'b00101;
        pulse_trig(2);
        wait_events(6);
        chan_en = 5'b00000;                 // fill completes with no go
        pulse_trig(2);
        wait_events(7);
        check_eq("go count", 67'd6, 67'(go_count));
        chan_en = 5'b11111;

        test_name = "back-pressure";
        daq_ready = 1'b0;
        base_go = go_count;
        for (int i = 0; i < 6; i++) pulse_trig(2);
        check_eq("accepted", 67'(TRIG_FIFO_DEPTH), 67'(go_count - base_go));
        check_eq("events", 67'd7, 67'(events_seen));
        daq_ready = 1'b1;
        wait_events(7 + TRIG_FIFO_DEPTH);
        pulse_trig(2);                      // numbering resumes without a gap
        wait_events(8 + TRIG_FIFO_DEPTH);

        test_name = "led";
        prev = led1;
        while (led1 == prev) step(1);
        prev = led1;
        cnt  = 0;
        while (led1 == prev) begin
            step(1);
            cnt++;
        end
        check_eq("half period", 67'(LED_HALF_CYCLES), 67'(cnt));
        daq_ready = 1'b0;
        step(1);
        check_eq("led0", '0, 67'(led0));
        daq_ready = 1'b1;
        step(2);

        $display("No errors");
        $finish;
    end

endmodule

//--- bench/tb_clk_gen.sv
// testbench clock and reset generator
module tb_clk_gen #(
    parameter real PERIOD_NS  = 8.0,    // 125 MHz
    parameter int  RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // release just after an edge so the first sampled cycle is clean
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- rtl/wfd_trig_top.sv
// master FPGA trigger and readout top with synchronizer, trigger FSM, FIFO, formatter, LEDs
module wfd_trig_top (
    input  logic                 clk125,        // main 125 MHz domain
    input  logic                 rst_n,
    input  logic                 ext_trig,      // front panel trigger
    input  trig_pkg::chan_mask_t chan_en,       // enabled channel fpgas
    input  trig_pkg::board_id_t  board_id,      // from the debug header straps
    input  trig_pkg::chan_mask_t acq_dones,     // done levels from the channels
    input  logic                 daq_ready,     // amc13 link ready
    output trig_pkg::chan_mask_t acq_trigs,     // go strobes to the channels
    output trig_pkg::chan_mask_t trig_arm,      // arm levels to the channels
    output daq_pkg::daq_word_t   daq_out,       // event words to the link
    output logic                 led0,          // green
    output logic                 led1           // red
);
    import trig_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////////////////////////

    logic      trig_edge;       // synchronized trigger pulse
    logic      fifo_push;       // trigger manager to fifo
    trig_num_t fifo_num;
    logic      fifo_full;
    logic      fmt_valid;       // fifo head to formatter
    logic      fmt_ready;
    trig_num_t fmt_num;

    // green shows link status
    assign led0 = daq_ready;

    trig_sync u_trig_sync (
        .clk       (clk125),
        .rst_n     (rst_n),
        .ext_trig  (ext_trig),
        .trig_edge (trig_edge)
    );

    trigger_fsm u_trigger_fsm (
        .clk       (clk125),
        .rst_n     (rst_n),
        .trig_edge (trig_edge),
        .chan_en   (chan_en),
        .acq_dones (acq_dones),
        .fifo_full (fifo_full),
        .acq_trigs (acq_trigs),
        .trig_arm  (trig_arm),
        .push      (fifo_push),
        .trig_num  (fifo_num)
    );

    trig_num_fifo u_trig_num_fifo (
        .clk       (clk125),
        .rst_n     (rst_n),
        .push      (fifo_push),
        .push_data (fifo_num),
        .full      (fifo_full),
        .pop_valid (fmt_valid),
        .pop_ready (fmt_ready),
        .pop_data  (fmt_num)
    );

    daq_formatter u_daq_formatter (
        .clk       (clk125),
        .rst_n     (rst_n),
        .in_valid  (fmt_valid),
        .in_ready  (fmt_ready),
        .in_num    (fmt_num),
        .board_id  (board_id),
        .chan_en   (chan_en),
        .daq_ready (daq_ready),
        .daq_out   (daq_out)
    );

    led_flasher u_led_flasher (
        .clk   (clk125),
        .rst_n (rst_n),
        .led   (led1)
    );

endmodule

//--- rtl/led_flasher.sv
// free-running cycle timer that blinks the red front-panel LED
module led_flasher (
    input  logic clk,
    input  logic rst_n,
    output logic led            // red led, low after reset
);
    import daq_pkg::*;

    localparam int CNT_W = $clog2(LED_HALF_CYCLES);

    logic [CNT_W-1:0] cnt;      // cycles into the half period

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            led <= 1'b0;
        end else if (cnt == CNT_W'(LED_HALF_CYCLES - 1)) begin
            cnt <= '0;
            led <= ~led;        // toggle at each wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- rtl/daq_formatter.sv
// DAQ event formatter turning each fill number into header, body and trailer words
module daq_formatter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,      // fill number at the fifo head
    output logic                 in_ready,      // pop, only on an accepted trailer
    input  trig_pkg::trig_num_t  in_num,
    input  trig_pkg::board_id_t  board_id,
    input  trig_pkg::chan_mask_t chan_en,
    input  logic                 daq_ready,     // link takes a word
    output daq_pkg::daq_word_t   daq_out
);
    import trig_pkg::*;
    import daq_pkg::*;

    localparam int IDX_W = $clog2(EVENT_WORDS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(EVENT_WORDS - 1);

    logic             out_valid;
    logic             out_hdr;
    logic             out_trl;
    logic [DAQ_W-1:0] out_data;         // payload, only read with out_valid
    logic [IDX_W-1:0] widx;             // index of the word on the link
    logic [IDX_W-1:0] next_idx;
    logic             accept;
    logic             load;

    // builds word idx of the event for fill n
    function automatic logic [DAQ_W-1:0] build_word(
        input logic [IDX_W-1:0] idx,
        input trig_num_t        n,
        input board_id_t        bid,
        input chan_mask_t       en
    );
        logic [DAQ_W-1:0] w;
        w = '0;
        w[TRIG_NUM_W-1:0] = n;              // fill number in every word
        if (idx == '0) begin
            w[63:56] = DAQ_HDR_TAG;
            w[34:32] = bid;
        end else if (idx == LAST_IDX) begin
            w[63:56] = DAQ_TRL_TAG;
            w[35:32] = 4'(EVENT_WORDS);
        end else begin
            w[36:32] = en;                  // body
        end
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // word sequencing
    //////////////////////////////////////////////////////////////////////

    assign accept   = out_valid & daq_ready;
    assign in_ready = accept & out_trl;                 // head leaves with its trailer

    // next header waits a cycle after a trailer so the head has moved
    assign next_idx = out_valid ? widx + 1'b1 : '0;
    assign load     = (accept && !out_trl) || (!out_valid && in_valid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_hdr   <= 1'b0;
            out_trl   <= 1'b0;
            widx      <= '0;
        end else if (accept && out_trl) begin
            out_valid <= 1'b0;                          // event complete
            out_hdr   <= 1'b0;
            out_trl   <= 1'b0;
            widx      <= '0;
        end else if (load) begin
            out_valid <= 1'b1;
            out_hdr   <= (next_idx == '0);
            out_trl   <= (next_idx == LAST_IDX);
            widx      <= next_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= build_word(next_idx, in_num, board_id, chan_en);
        end
    end

    assign daq_out = '{valid: out_valid, header: out_hdr, trailer: out_trl, data: out_data};

    a_hdr_trl_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(daq_out.header && daq_out.trailer))
        else $error("daq word flagged as both header and trailer");

endmodule

//--- trigger/trig_num_fifo.sv
// synchronous register-array FIFO of fill numbers with valid/ready read side
module trig_num_fifo #(
    parameter int DEPTH = trig_pkg::TRIG_FIFO_DEPTH
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,       // write strobe from the trigger manager
    input  trig_pkg::trig_num_t push_data,
    output logic                full,
    output logic                pop_valid,  // head entry present
    input  logic                pop_ready,  // formatter takes the head
    output trig_pkg::trig_num_t pop_data
);
    import trig_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    trig_num_t  mem [DEPTH];    // entry storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;    // entries held
    logic do_push;
    logic do_pop;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];                 // stable until popped

    assign do_push = push & ~full;
    assign do_pop  = pop_valid & pop_ready;

    //////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // none or both
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;           // visible at the head next cycle
        end
    end

    a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full)
        else $error("push while trigger number fifo is full");

endmodule

//--- trigger/trigger_fsm.sv
// trigger manager FSM with channel arm, go strobe, done collection and fill counter
module trigger_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 trig_edge,     // synchronized trigger pulse
    input  trig_pkg::chan_mask_t chan_en,       // enabled channels
    input  trig_pkg::chan_mask_t acq_dones,     // done levels from the channels
    input  logic                 fifo_full,     // trigger number fifo has no room
    output trig_pkg::chan_mask_t acq_trigs,     // go strobe to the channels
    output trig_pkg::chan_mask_t trig_arm,      // arm level to the channels
    output logic                 push,          // write strobe into the fifo
    output trig_pkg::trig_num_t  trig_num       // number of the finished fill
);
    import trig_pkg::*;

    trig_state_t state;
    trig_state_t state_nxt;
    chan_mask_t  en_q;          // channels that took part in this fill
    trig_num_t   fill_cnt;      // next fill number
    logic        all_done;
    logic        fire;

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    // a fill with no channels enabled is done at once
    assign all_done = ((acq_dones & en_q) == en_q);

    // trigger accepted only when armed and the fifo has room
    assign fire = (state == TS_IDLE) && trig_edge && !fifo_full;

    always_comb begin
        state_nxt = state;
        case (state)
            TS_IDLE: begin
                if (fire) begin
                    state_nxt = TS_FIRE;
                end
            end
            TS_FIRE: begin
                state_nxt = TS_WAIT_DONE;   // go is out this cycle
            end
            TS_WAIT_DONE: begin
                if (all_done) begin
                    state_nxt = TS_PUSH;
                end
            end
            TS_PUSH: begin
                state_nxt = TS_IDLE;        // re-arm
            end
            default: begin
                state_nxt = TS_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state, go strobe and fill counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= TS_IDLE;
            acq_trigs <= '0;
            en_q      <= '0;
            fill_cnt  <= '0;
        end else begin
            state     <= state_nxt;
            acq_trigs <= fire ? chan_en : '0;   // one cycle, the cycle after the edge
            if (fire) begin
                en_q <= chan_en;                // later chan_en changes wait for next fill
            end
            if (state == TS_PUSH) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // channels are armed only while idle
    assign trig_arm = (state == TS_IDLE) ? chan_en : '0;

    assign push     = (state == TS_PUSH);
    assign trig_num = fill_cnt;                 // count before the increment

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    a_go_single : assert property (@(posedge clk) disable iff (!rst_n)
        (|acq_trigs) |=> !(|acq_trigs))
        else $error("go strobe held for more than one cycle");

    // fullness comes from the fifo so this ties both blocks together
    a_push_room : assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !fifo_full)
        else $error("fill number pushed into a full fifo");

endmodule

//--- rtl/trig_sync.sv
// front-panel trigger synchronizer and rising-edge pulse generator
module trig_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic ext_trig,      // asynchronous front panel level
    output logic trig_edge      // one-cycle pulse per rising edge
);

    logic [1:0] sync_q;         // two-stage synchronizer, [1] is safe to use
    logic       prev_q;         // last synchronized level

    // edge 1 samples the pin, edge 2 settles, edge 3 fires the pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q    <= 2'b00;
            prev_q    <= 1'b0;
            trig_edge <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], ext_trig};
            prev_q    <= sync_q[1];
            trig_edge <= sync_q[1] & ~prev_q;   // high for one cycle only
        end
    end

endmodule

//--- common/daq_pkg.sv
// daq link word struct, header and trailer tags, event length and led timing constants
package daq_pkg;

    //////////////////////////////////////////////////////////////////////
    // amc13 daq link word
    //////////////////////////////////////////////////////////////////////

    localparam int DAQ_W = 64;      // event data width of the link

    // one word as presented to the link
    typedef struct packed {
        logic             valid;    // word present
        logic             header;   // first word of an event
        logic             trailer;  // last word of an event
        logic [DAQ_W-1:0] data;
    } daq_word_t;

    // tags in bits 63..56
    localparam logic [7:0] DAQ_HDR_TAG = 8'h5a;
    localparam logic [7:0] DAQ_TRL_TAG = 8'ha5;

    // header, body, trailer
    localparam int EVENT_WORDS = 3;

    //////////////////////////////////////////////////////////////////////
    // front panel led
    //////////////////////////////////////////////////////////////////////

    // clock cycles per half period of the red led
    localparam int LED_HALF_CYCLES = 256;

endpackage

//--- common/trig_pkg.sv
// trigger path constants, channel mask, board id and fill number types, trigger manager states
package trig_pkg;

    //////////////////////////////////////////////////////////////////////
    // channel fan-out
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_CHAN = 5;                // channel fpgas behind the master

    typedef logic [NUM_CHAN-1:0] chan_mask_t;   // one bit per channel

    // board identifier strapped on the debug header
    localparam int BOARD_ID_W = 3;

    typedef logic [BOARD_ID_W-1:0] board_id_t;

    //////////////////////////////////////////////////////////////////////
    // fill numbering
    //////////////////////////////////////////////////////////////////////

    localparam int TRIG_NUM_W = 24;             // fill counter width

    typedef logic [TRIG_NUM_W-1:0] trig_num_t;

    // fills that may queue while the daq link stalls
    localparam int TRIG_FIFO_DEPTH = 4;

    //////////////////////////////////////////////////////////////////////
    // trigger manager states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        TS_IDLE      = 2'd0,    // armed and waiting for a trigger edge
        TS_FIRE      = 2'd1,    // go pulse out to the enabled channels
        TS_WAIT_DONE = 2'd2,    // channels digitizing
        TS_PUSH      = 2'd3     // fill number into the fifo
    } trig_state_t;

endpackage
